// File: Bender.yml
package:
  name: aes_decrypt

sources:
  - logic/aes_ctrl_pkg.sv
  - logic/aes_gf_pkg.sv
  - logic/aes_key_expand.sv
  - logic/aes_inv_mix_column.sv
  - logic/aes_decrypt.sv
  - target: simulation
    files:
      - tb/tb_clock_gen.sv
      - tb/aes_decrypt_assert.sv
      - tb/aes_decrypt_tb.sv

// File: logic/aes_ctrl_pkg.sv
// ==========================================================
// AES-128 decryption control definitions.
// Data widths, round count and the controller state encoding.
// ==========================================================

package aes_ctrl_pkg;

	localparam int BLOCK_W = 128;
	localparam int WORD_W = 32;

	// Round key index, 0 to 10.
	typedef logic [3:0] round_idx_t;

	localparam round_idx_t NUM_ROUNDS = 4'd10;

	typedef enum logic [3:0]
	{
		WAIT,
		KEY_EXPANSION,
		INITIAL_ROUND,
		LOOP_INVSHIFTROW,
		LOOP_INVSUB,
		LOOP_ADDRK,
		LOOP_INVMIXCOL1,
		LOOP_INVMIXCOL2,
		LOOP_INVMIXCOL3,
		LOOP_INVMIXCOL4,
		INVSHIFTROW,
		INVSUB,
		ADDRK,
		DONE
	} aes_state_e;

endpackage

// File: logic/aes_decrypt.sv
// ==========================================================
// AES-128 decryption core.
// Multi-cycle inverse cipher, one transform per FSM state,
// with an iterative key expander and a single mix column unit.
// ==========================================================

`timescale 1ns/100ps

module aes_decrypt (
	input  logic                             CLK,
	input  logic                             RESET,
	input  logic                             aes_start,
	input  logic [aes_ctrl_pkg::BLOCK_W-1:0] aes_key,
	input  logic [aes_ctrl_pkg::BLOCK_W-1:0] aes_msg_enc,
	output logic                             aes_done,
	output logic [aes_ctrl_pkg::BLOCK_W-1:0] aes_msg_dec
);

	aes_ctrl_pkg::aes_state_e          ctrl_state;
	aes_ctrl_pkg::aes_state_e          ctrl_next;
	aes_ctrl_pkg::round_idx_t          round_idx;
	aes_ctrl_pkg::round_idx_t          round_next;
	logic [aes_ctrl_pkg::BLOCK_W-1:0]  blk_q;
	logic [aes_ctrl_pkg::BLOCK_W-1:0]  blk_d;
	logic [aes_ctrl_pkg::BLOCK_W-1:0]  shift_out;
	logic [aes_ctrl_pkg::BLOCK_W-1:0]  sub_out;
	logic [aes_ctrl_pkg::BLOCK_W-1:0]  ark_out;
	logic [aes_ctrl_pkg::BLOCK_W-1:0]  round_key;
	logic [aes_ctrl_pkg::WORD_W-1:0]   mix_in;
	logic [aes_ctrl_pkg::WORD_W-1:0]   mix_out;
	logic [1:0]                        mix_col;
	logic                              expand_start;
	logic                              keys_ready;

	assign expand_start = (ctrl_state == aes_ctrl_pkg::WAIT) && aes_start;

	aes_key_expand i_key_expand (
		.CLK          (CLK),
		.RESET        (RESET),
		.expand_start (expand_start),
		.cipher_key   (aes_key),
		.round_sel    (round_idx),
		.round_key    (round_key),
		.keys_ready   (keys_ready)
	);

	aes_inv_mix_column i_inv_mix_column (
		.mix_in  (mix_in),
		.mix_out (mix_out)
	);

	// Byte (row r, column c) is byte 4c+r, counted from the top.
	always_comb
	begin
		for (int r = 0; r < 4; r++)
		begin
			for (int c = 0; c < 4; c++)
			begin
				shift_out[127 - 8*(4*c + r) -: 8] = blk_q[127 - 8*(4*((c - r) & 3) + r) -: 8];
			end
		end
	end

	always_comb
	begin
		for (int i = 0; i < 16; i++)
		begin
			sub_out[8*i +: 8] = aes_gf_pkg::INV_SBOX[blk_q[8*i +: 8]];
		end
	end

	assign ark_out = blk_q ^ round_key;

	// Column 0 is the top word.
	always_comb
	begin
		case (ctrl_state)
			aes_ctrl_pkg::LOOP_INVMIXCOL2: mix_col = 2'd1;
			aes_ctrl_pkg::LOOP_INVMIXCOL3: mix_col = 2'd2;
			aes_ctrl_pkg::LOOP_INVMIXCOL4: mix_col = 2'd3;
			default:                       mix_col = 2'd0;
		endcase
	end

	assign mix_in = blk_q[127 - 32*mix_col -: 32];

	// Next state and round index.
	always_comb
	begin
		ctrl_next = ctrl_state;
		round_next = round_idx;
		case (ctrl_state)
			aes_ctrl_pkg::WAIT:
			begin
				if (aes_start)
				begin
					ctrl_next = aes_ctrl_pkg::KEY_EXPANSION;
					round_next = aes_ctrl_pkg::NUM_ROUNDS;
				end
			end
			aes_ctrl_pkg::KEY_EXPANSION:
			begin
				if (keys_ready)
				begin
					ctrl_next = aes_ctrl_pkg::INITIAL_ROUND;
				end
			end
			aes_ctrl_pkg::INITIAL_ROUND:
			begin
				ctrl_next = aes_ctrl_pkg::LOOP_INVSHIFTROW;
				round_next = round_idx - 4'd1;
			end
			aes_ctrl_pkg::LOOP_INVSHIFTROW: ctrl_next = aes_ctrl_pkg::LOOP_INVSUB;
			aes_ctrl_pkg::LOOP_INVSUB:      ctrl_next = aes_ctrl_pkg::LOOP_ADDRK;
			aes_ctrl_pkg::LOOP_ADDRK:       ctrl_next = aes_ctrl_pkg::LOOP_INVMIXCOL1;
			aes_ctrl_pkg::LOOP_INVMIXCOL1:  ctrl_next = aes_ctrl_pkg::LOOP_INVMIXCOL2;
			aes_ctrl_pkg::LOOP_INVMIXCOL2:  ctrl_next = aes_ctrl_pkg::LOOP_INVMIXCOL3;
			aes_ctrl_pkg::LOOP_INVMIXCOL3:  ctrl_next = aes_ctrl_pkg::LOOP_INVMIXCOL4;
			aes_ctrl_pkg::LOOP_INVMIXCOL4:
			begin
				// Round 1 was the last full round.
				if (round_idx == 4'd1)
				begin
					ctrl_next = aes_ctrl_pkg::INVSHIFTROW;
				end
				else
				begin
					ctrl_next = aes_ctrl_pkg::LOOP_INVSHIFTROW;
				end
				round_next = round_idx - 4'd1;
			end
			aes_ctrl_pkg::INVSHIFTROW: ctrl_next = aes_ctrl_pkg::INVSUB;
			aes_ctrl_pkg::INVSUB:      ctrl_next = aes_ctrl_pkg::ADDRK;
			aes_ctrl_pkg::ADDRK:       ctrl_next = aes_ctrl_pkg::DONE;
			aes_ctrl_pkg::DONE:
			begin
				if (!aes_start)
				begin
					ctrl_next = aes_ctrl_pkg::WAIT;
				end
			end
			default: ctrl_next = aes_ctrl_pkg::WAIT;
		endcase
	end

	// State register contents.
	always_comb
	begin
		blk_d = blk_q;
		case (ctrl_state)
			aes_ctrl_pkg::WAIT:
			begin
				if (aes_start)
				begin
					blk_d = aes_msg_enc;
				end
			end
			aes_ctrl_pkg::INITIAL_ROUND,
			aes_ctrl_pkg::LOOP_ADDRK,
			aes_ctrl_pkg::ADDRK:       blk_d = ark_out;
			aes_ctrl_pkg::LOOP_INVSHIFTROW,
			aes_ctrl_pkg::INVSHIFTROW: blk_d = shift_out;
			aes_ctrl_pkg::LOOP_INVSUB,
			aes_ctrl_pkg::INVSUB:      blk_d = sub_out;
			aes_ctrl_pkg::LOOP_INVMIXCOL1,
			aes_ctrl_pkg::LOOP_INVMIXCOL2,
			aes_ctrl_pkg::LOOP_INVMIXCOL3,
			aes_ctrl_pkg::LOOP_INVMIXCOL4: blk_d[127 - 32*mix_col -: 32] = mix_out;
			default: blk_d = blk_q;
		endcase
	end

	always_ff @(posedge CLK)
	begin
		if (RESET)
		begin
			ctrl_state <= aes_ctrl_pkg::WAIT;
			round_idx <= 4'd0;
		end
		else
		begin
			ctrl_state <= ctrl_next;
			round_idx <= round_next;
		end
	end

	always_ff @(posedge CLK)
	begin
		blk_q <= blk_d;
	end

	assign aes_done = (ctrl_state == aes_ctrl_pkg::DONE);
	assign aes_msg_dec = aes_done ? blk_q : '0;

endmodule

// File: logic/aes_gf_pkg.sv
// ==========================================================
// AES field arithmetic and substitution tables.
// Forward and inverse S-boxes, round constants and GF(2^8)
// multiplies for the inverse mix columns step.
// ==========================================================

package aes_gf_pkg;

	// Forward S-box, entry 0 in the leftmost byte.
	localparam logic [0:255][7:0] SBOX =
	{
		128'h637c777bf26b6fc53001672bfed7ab76,
		128'hca82c97dfa5947f0add4a2af9ca472c0,
		128'hb7fd9326363ff7cc34a5e5f171d83115,
		128'h04c723c31896059a071280e2eb27b275,
		128'h09832c1a1b6e5aa0523bd6b329e32f84,
		128'h53d100ed20fcb15b6acbbe394a4c58cf,
		128'hd0efaafb434d338545f9027f503c9fa8,
		128'h51a3408f929d38f5bcb6da2110fff3d2,
		128'hcd0c13ec5f974417c4a77e3d645d1973,
		128'h60814fdc222a908846eeb814de5e0bdb,
		128'he0323a0a4906245cc2d3ac629195e479,
		128'he7c8376d8dd54ea96c56f4ea657aae08,
		128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
		128'h703eb5664803f60e613557b986c11d9e,
		128'he1f8981169d98e949b1e87e9ce5528df,
		128'h8ca1890dbfe6426841992d0fb054bb16
	};

	// Inverse S-box.
	localparam logic [0:255][7:0] INV_SBOX =
	{
		128'h52096ad53036a538bf40a39e81f3d7fb,
		128'h7ce339829b2fff87348e4344c4dee9cb,
		128'h547b9432a6c2233dee4c950b42fac34e,
		128'h082ea16628d924b2765ba2496d8bd125,
		128'h72f8f66486689816d4a45ccc5d65b692,
		128'h6c704850fdedb9da5e154657a78d9d84,
		128'h90d8ab008cbcd30af7e45805b8b34506,
		128'hd02c1e8fca3f0f02c1afbd0301138a6b,
		128'h3a9111414f67dcea97f2cfcef0b4e673,
		128'h96ac7422e7ad3585e2f937e81c75df6e,
		128'h47f11a711d29c5896fb7620eaa18be1b,
		128'hfc563e4bc6d279209adbc0fe78cd5af4,
		128'h1fdda8338807c731b11210592780ec5f,
		128'h60517fa919b54a0d2de57a9f93c99cef,
		128'ha0e03b4dae2af5b0c8ebbb3c83539961,
		128'h172b047eba77d626e169146355210c7d
	};

	// Round constants, indexed by the round key number 1 to 10.
	localparam logic [1:10][7:0] RCON = 80'h01020408102040801b36;

	// Multiply by x modulo x^8 + x^4 + x^3 + x + 1.
	function automatic logic [7:0] xtime(input logic [7:0] b);
		return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
	endfunction

	// Multiply by a 4-bit constant, built from repeated xtime.
	function automatic logic [7:0] gf_mul(input logic [7:0] b, input logic [3:0] c);
		logic [7:0] x2;
		logic [7:0] x4;
		logic [7:0] x8;
		x2 = xtime(b);
		x4 = xtime(x2);
		x8 = xtime(x4);
		return ({8{c[0]}} & b) ^ ({8{c[1]}} & x2) ^ ({8{c[2]}} & x4) ^ ({8{c[3]}} & x8);
	endfunction

endpackage

// File: logic/aes_inv_mix_column.sv
// ==========================================================
// AES inverse mix columns for a single 32-bit column.
// ==========================================================

`timescale 1ns/100ps

module aes_inv_mix_column (
	input  logic [aes_ctrl_pkg::WORD_W-1:0] mix_in,
	output logic [aes_ctrl_pkg::WORD_W-1:0] mix_out
);

	logic [7:0] a [0:3];
	logic [7:0] b [0:3];

	// Row 0 sits in the top byte.
	always_comb
	begin
		for (int r = 0; r < 4; r++)
		begin
			a[r] = mix_in[31 - 8*r -: 8];
		end
	end

	// Each output row uses the circulant 0e 0b 0d 09 rotated by its row.
	always_comb
	begin
		for (int r = 0; r < 4; r++)
		begin
			b[r] = aes_gf_pkg::gf_mul(a[r], 4'd14)
				^ aes_gf_pkg::gf_mul(a[(r + 1) % 4], 4'd11)
				^ aes_gf_pkg::gf_mul(a[(r + 2) % 4], 4'd13)
				^ aes_gf_pkg::gf_mul(a[(r + 3) % 4], 4'd9);
		end
	end

	assign mix_out = {b[0], b[1], b[2], b[3]};

endmodule

// File: logic/aes_key_expand.sv
// ==========================================================
// AES-128 key expander.
// Builds the eleven round keys one per cycle and holds them
// for lookup by round index.
// ==========================================================

`timescale 1ns/100ps

module aes_key_expand (
	input  logic                                CLK,
	input  logic                                RESET,
	input  logic                                expand_start,
	input  logic [aes_ctrl_pkg::BLOCK_W-1:0]    cipher_key,
	input  aes_ctrl_pkg::round_idx_t            round_sel,
	output logic [aes_ctrl_pkg::BLOCK_W-1:0]    round_key,
	output logic                                keys_ready
);

	logic [aes_ctrl_pkg::BLOCK_W-1:0] key_mem [0:aes_ctrl_pkg::NUM_ROUNDS];
	logic [aes_ctrl_pkg::BLOCK_W-1:0] prev_key;
	logic [aes_ctrl_pkg::BLOCK_W-1:0] next_key;
	logic [aes_ctrl_pkg::WORD_W-1:0]  sub_rot;
	logic [aes_ctrl_pkg::WORD_W-1:0]  temp_word;
	aes_ctrl_pkg::round_idx_t         build_idx;
	logic                             busy;

	// Index of the key being built, never 0 so the previous key is valid.
	assign prev_key = key_mem[build_idx - 4'd1];

	// RotWord then SubWord on the last word of the previous key.
	assign sub_rot = {aes_gf_pkg::SBOX[prev_key[23:16]],
		aes_gf_pkg::SBOX[prev_key[15:8]],
		aes_gf_pkg::SBOX[prev_key[7:0]],
		aes_gf_pkg::SBOX[prev_key[31:24]]};

	assign temp_word = sub_rot ^ {aes_gf_pkg::RCON[build_idx], 24'h000000};

	// Each new word chains on the one before it.
	assign next_key[127:96] = prev_key[127:96] ^ temp_word;
	assign next_key[95:64]  = prev_key[95:64] ^ next_key[127:96];
	assign next_key[63:32]  = prev_key[63:32] ^ next_key[95:64];
	assign next_key[31:0]   = prev_key[31:0] ^ next_key[63:32];

	always_ff @(posedge CLK)
	begin
		if (RESET)
		begin
			busy <= 1'b0;
			keys_ready <= 1'b0;
			build_idx <= 4'd1;
		end
		else if (expand_start)
		begin
			busy <= 1'b1;
			keys_ready <= 1'b0;
			build_idx <= 4'd1;
		end
		else if (busy)
		begin
			if (build_idx == aes_ctrl_pkg::NUM_ROUNDS)
			begin
				busy <= 1'b0;
				keys_ready <= 1'b1;
			end
			else
			begin
				build_idx <= build_idx + 4'd1;
			end
		end
	end

	// Key 0 is the cipher key itself.
	always_ff @(posedge CLK)
	begin
		if (expand_start)
		begin
			key_mem[0] <= cipher_key;
		end
		else if (busy)
		begin
			key_mem[build_idx] <= next_key;
		end
	end

	assign round_key = key_mem[round_sel];

endmodule

// File: tb.f
logic/aes_ctrl_pkg.sv
logic/aes_gf_pkg.sv
logic/aes_key_expand.sv
logic/aes_inv_mix_column.sv
logic/aes_decrypt.sv
tb/tb_clock_gen.sv
tb/aes_decrypt_assert.sv
tb/aes_decrypt_tb.sv

// File: tb/aes_decrypt_assert.sv
// ==========================================================
// Concurrent checks on the AES-128 decryption core outputs.
// ==========================================================

`timescale 1ns/100ps

module aes_decrypt_assert (
	input  logic                             CLK,
	input  logic                             RESET,
	input  logic                             aes_start,
	input  logic                             aes_done,
	input  logic [aes_ctrl_pkg::BLOCK_W-1:0] aes_msg_dec,
	input  logic [aes_ctrl_pkg::BLOCK_W-1:0] expected_plain
);

	// Plaintext matches the vector whenever done is up.
	plain_match: assert property (@(posedge CLK) disable iff (RESET)
		aes_done |-> aes_msg_dec == expected_plain)
	else
	begin
		$error("FAIL %0t aes_msg_dec got %h expected %h", $time,
			$sampled(aes_msg_dec), $sampled(expected_plain));
		aes_decrypt_tb.assert_errors++;
	end

	done_hold: assert property (@(posedge CLK) disable iff (RESET)
		aes_done && aes_start |=> aes_done && $stable(aes_msg_dec))
	else
	begin
		$error("Done or plaintext changed at %0t while aes_start was held high", $time);
		aes_decrypt_tb.assert_errors++;
	end

	done_release: assert property (@(posedge CLK) disable iff (RESET)
		aes_done && !aes_start |=> !aes_done)
	else
	begin
		$error("aes_done still high at %0t one cycle after aes_start dropped", $time);
		aes_decrypt_tb.assert_errors++;
	end

	// Output is masked outside DONE.
	msg_masked: assert property (@(posedge CLK) disable iff (RESET)
		!aes_done |-> aes_msg_dec == '0)
	else
	begin
		$error("FAIL %0t aes_msg_dec got %h expected %h", $time,
			$sampled(aes_msg_dec), {aes_ctrl_pkg::BLOCK_W{1'b0}});
		aes_decrypt_tb.assert_errors++;
	end

	done_needs_start: assert property (@(posedge CLK) disable iff (RESET)
		$rose(aes_done) |-> aes_start)
	else
	begin
		$error("aes_done rose at %0t without aes_start high", $time);
		aes_decrypt_tb.assert_errors++;
	end

	done_after_reset: assert property (@(posedge CLK)
		RESET |=> !aes_done)
	else
	begin
		$error("FAIL %0t aes_done got %b expected 0", $time, $sampled(aes_done));
		aes_decrypt_tb.assert_errors++;
	end

endmodule

// File: tb/aes_decrypt_tb.sv
// ==========================================================
// AES-128 decryption testbench.
// Runs published vectors, a held done and resets both mid-run
// and in done, with the bound assertions doing the checking.
// ==========================================================

`timescale 1ns/100ps

module aes_decrypt_tb;

	localparam int TIMEOUT_CYCLES = 200;
	localparam int HOLD_CYCLES = 20;
	localparam int IDLE_CYCLES = 100;

	localparam logic [127:0] KEY_1 = 128'h000102030405060708090a0b0c0d0e0f;
	localparam logic [127:0] CT_1 = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
	localparam logic [127:0] PLAIN_1 = 128'h00112233445566778899aabbccddeeff;
	localparam logic [127:0] KEY_2 = 128'h2b7e151628aed2a6abf7158809cf4f3c;
	localparam logic [127:0] CT_2 = 128'h3ad77bb40d7a3660a89ecaf32466ef97;
	localparam logic [127:0] PLAIN_2 = 128'h6bc1bee22e409f96e93d7e117393172a;

	logic                             CLK;
	logic                             RESET;
	logic                             por_reset;
	logic                             mid_reset;
	logic                             aes_start;
	logic [aes_ctrl_pkg::BLOCK_W-1:0] aes_key;
	logic [aes_ctrl_pkg::BLOCK_W-1:0] aes_msg_enc;
	logic                             aes_done;
	logic [aes_ctrl_pkg::BLOCK_W-1:0] aes_msg_dec;
	logic [aes_ctrl_pkg::BLOCK_W-1:0] expected_plain;
	int                               assert_errors;
	int                               timeout_errors;

	assign RESET = por_reset | mid_reset;

	tb_clock_gen i_clock_gen (
		.CLK   (CLK),
		.RESET (por_reset)
	);

	aes_decrypt i_dut (
		.CLK         (CLK),
		.RESET       (RESET),
		.aes_start   (aes_start),
		.aes_key     (aes_key),
		.aes_msg_enc (aes_msg_enc),
		.aes_done    (aes_done),
		.aes_msg_dec (aes_msg_dec)
	);

	bind aes_decrypt aes_decrypt_assert i_assert (
		.CLK            (CLK),
		.RESET          (RESET),
		.aes_start      (aes_start),
		.aes_done       (aes_done),
		.aes_msg_dec    (aes_msg_dec),
		.expected_plain (aes_decrypt_tb.expected_plain)
	);

	// Inputs change just after the rising edge.
	task automatic step_cycle;
		@(posedge CLK);
		#2;
	endtask

	// Polled on the falling edge, where the outputs are settled.
	task automatic wait_done_level(input logic level, input string what);
		int cycles;
		cycles = 0;
		while (aes_done !== level && cycles < TIMEOUT_CYCLES)
		begin
			@(negedge CLK);
			cycles++;
		end
		if (aes_done !== level)
		begin
			$display("TIMEOUT at %0t: %s did not happen within %0d cycles",
				$time, what, TIMEOUT_CYCLES);
			timeout_errors++;
		end
	endtask

	task automatic wait_reset_release;
		int cycles;
		cycles = 0;
		while (RESET !== 1'b0 && cycles < TIMEOUT_CYCLES)
		begin
			@(negedge CLK);
			cycles++;
		end
		if (RESET !== 1'b0)
		begin
			$display("TIMEOUT at %0t: reset was never released", $time);
			timeout_errors++;
		end
	endtask

	// One block, with start held for a while after done.
	task automatic decrypt_block(input logic [127:0] key, input logic [127:0] ct,
		input logic [127:0] plain);
		step_cycle();
		aes_key = key;
		aes_msg_enc = ct;
		expected_plain = plain;
		aes_start = 1'b1;
		wait_done_level(1'b1, "aes_done rising");
		repeat (HOLD_CYCLES) step_cycle();
		aes_start = 1'b0;
		wait_done_level(1'b0, "aes_done falling");
	endtask

	// Reset lands while done is held and start is still high.
	task automatic reset_in_done;
		step_cycle();
		aes_key = KEY_2;
		aes_msg_enc = CT_2;
		expected_plain = PLAIN_2;
		aes_start = 1'b1;
		wait_done_level(1'b1, "aes_done rising before reset");
		step_cycle();
		mid_reset = 1'b1;
		repeat (2) step_cycle();
		mid_reset = 1'b0;
		aes_start = 1'b0;
	endtask

	// Reset lands inside the loop rounds.
	// Start then stays low for longer than a whole run.
	task automatic reset_mid_run;
		step_cycle();
		aes_key = KEY_1;
		aes_msg_enc = CT_1;
		expected_plain = PLAIN_1;
		aes_start = 1'b1;
		repeat (30) step_cycle();
		mid_reset = 1'b1;
		aes_start = 1'b0;
		repeat (2) step_cycle();
		mid_reset = 1'b0;
		repeat (IDLE_CYCLES) step_cycle();
	endtask

	initial
	begin
		mid_reset = 1'b0;
		aes_start = 1'b0;
		aes_key = '0;
		aes_msg_enc = '0;
		expected_plain = '0;
		assert_errors = 0;
		timeout_errors = 0;

		wait_reset_release();
		decrypt_block(KEY_1, CT_1, PLAIN_1);
		decrypt_block(KEY_2, CT_2, PLAIN_2);
		reset_in_done();
		reset_mid_run();
		decrypt_block(KEY_1, CT_1, PLAIN_1);
		repeat (4) step_cycle();

		$display("Errors: %0d assertion failures, %0d timeouts", assert_errors,
			timeout_errors);
		if (assert_errors == 0 && timeout_errors == 0)
		begin
			$display("PASS: all tests");
		end
		else
		begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

// File: tb/tb_clock_gen.sv
// ==========================================================
// Testbench clock and power-on reset.
// 40 ns clock, reset held high for the first 4 cycles.
// ==========================================================

`timescale 1ns/100ps

module tb_clock_gen (
	output logic CLK,
	output logic RESET
);

	initial
	begin
		CLK = 1'b0;
		forever #20 CLK = ~CLK;
	end

	// Release lines up with the stimulus delay.
	initial
	begin
		RESET = 1'b1;
		repeat (4) @(posedge CLK);
		#2;
		RESET = 1'b0;
	end

endmodule
